/* design/dsp_settings.svh */
// Field layout of the instruction assumes 16-bit words, 8-bit addresses and four pointers
`ifndef DSP_SETTINGS_SVH
`define DSP_SETTINGS_SVH

// Data and instruction word
`define DSP_WORD_W 16

// Accumulator with guard bits
`define DSP_ACC_W 36

// Program and data memory address widths
`define DSP_ROM_AW 8
`define DSP_RAM_AW 8

// RAM pointer registers r0..r3
`define DSP_NPTR 4

`endif

/* design/dsp_pkg.sv */
// Opcode values are fixed by the program encoding; codes 13 to 15 decode as no-ops
`include "dsp_settings.svh"

package dsp_pkg;

    typedef logic [`DSP_WORD_W-1:0] word_t;
    typedef logic signed [`DSP_ACC_W-1:0] acc_t;

    typedef enum logic [3:0] {
        op_nop  = 4'd0,
        op_halt = 4'd1,
        op_ldr  = 4'd2,
        op_ldx  = 4'd3,
        op_ldy  = 4'd4,
        op_rdy  = 4'd5,
        op_wra  = 4'd6,
        op_mac  = 4'd7,
        op_clr  = 4'd8,
        op_outl = 4'd9,
        op_outh = 4'd10,
        op_inp  = 4'd11,
        op_goto = 4'd12
    } opcode_e;

    // Opcode in the top nibble, operand field below
    typedef struct packed {
        opcode_e     opcode;
        logic [11:0] field;
    } instr_t;

    typedef enum logic [1:0] {
        st_idle,
        st_fetch,
        st_exec,
        st_halt
    } seq_state_e;

    typedef enum logic [2:0] {
        dau_none,
        dau_ldx,
        dau_ldy_imm,
        dau_ldy_ram,
        dau_ldy_pin,
        dau_mac,
        dau_clr
    } dau_op_e;

endpackage

/* design/dsp_if.sv */
// All commands are single-cycle strobes that the receiver always accepts, no handshake
`include "dsp_settings.svh"

// Pointer and RAM commands
interface aau_if import dsp_pkg::*; ();
    logic [$clog2(`DSP_NPTR)-1:0] ptr_sel;
    logic                         ptr_load;
    logic [`DSP_RAM_AW-1:0]       ptr_imm;
    logic                         ram_rd;
    logic                         ram_wr;
    logic                         post_inc;
    word_t                        ram_dout;

    modport ctrl (
        output ptr_sel, ptr_load, ptr_imm, ram_rd, ram_wr, post_inc
    );
    modport aau (
        input  ptr_sel, ptr_load, ptr_imm, ram_rd, ram_wr, post_inc,
        output ram_dout
    );
endinterface

// Arithmetic unit operation and accumulator
interface dau_if import dsp_pkg::*; ();
    dau_op_e dau_op;
    word_t   imm;
    acc_t    a0;

    modport ctrl (output dau_op, imm);
    modport dau  (input dau_op, imm, output a0);
endinterface

// Parallel port strobes
interface pio_if import dsp_pkg::*; ();
    logic  out_stb;
    logic  out_high;
    logic  in_stb;
    word_t pin_word;

    modport ctrl (output out_stb, out_high, in_stb);
    modport pio  (input out_stb, out_high, in_stb, output pin_word);
endinterface

/* design/dsp_ctrl.sv */
// Every instruction takes fetch plus exec; no conditional branches, pc wraps at 256
`include "dsp_settings.svh"

module dsp_ctrl import dsp_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   run,
    output logic [`DSP_ROM_AW-1:0] fetch_addr,
    input  instr_t                 instr,
    output logic                   halted,
    aau_if.ctrl                    aau,
    dau_if.ctrl                    dau,
    pio_if.ctrl                    pio
);

    seq_state_e             state;
    logic [`DSP_ROM_AW-1:0] pc;
    logic [`DSP_ROM_AW-1:0] pc_next;
    logic                   halt_cmd;

    assign fetch_addr = pc;
    assign halted     = (state == st_halt);

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            state <= st_idle;
            pc    <= '0;
        end else begin
            case (state)
                st_idle: begin
                    if (run) begin
                        state <= st_fetch;
                    end
                end
                // ROM output is registered, instruction ready next cycle
                st_fetch: state <= st_exec;
                st_exec: begin
                    if (halt_cmd) begin
                        state <= st_halt;
                    end else begin
                        state <= st_fetch;
                        pc    <= pc_next;
                    end
                end
                st_halt: begin
                    // Restart from address 0, datapath registers keep their values
                    if (!run) begin
                        state <= st_idle;
                        pc    <= '0;
                    end
                end
                default: state <= st_idle;
            endcase
        end
    end

    // Decode, active only in st_exec
    always_comb begin
        halt_cmd     = 1'b0;
        pc_next      = pc + 1'b1;
        aau.ptr_sel  = instr.field[11:10];
        aau.ptr_imm  = instr.field[7:0];
        aau.post_inc = instr.field[9];
        aau.ptr_load = 1'b0;
        aau.ram_rd   = 1'b0;
        aau.ram_wr   = 1'b0;
        dau.dau_op   = dau_none;
        dau.imm      = {{(`DSP_WORD_W-12){instr.field[11]}}, instr.field};
        pio.out_stb  = 1'b0;
        pio.out_high = 1'b0;
        pio.in_stb   = 1'b0;
        if (state == st_exec) begin
            case (instr.opcode)
                op_halt: halt_cmd     = 1'b1;
                op_ldr:  aau.ptr_load = 1'b1;
                op_ldx:  dau.dau_op   = dau_ldx;
                op_ldy:  dau.dau_op   = dau_ldy_imm;
                op_rdy: begin
                    aau.ram_rd = 1'b1;
                    dau.dau_op = dau_ldy_ram;
                end
                op_wra:  aau.ram_wr   = 1'b1;
                op_mac:  dau.dau_op   = dau_mac;
                op_clr:  dau.dau_op   = dau_clr;
                op_outl: pio.out_stb  = 1'b1;
                op_outh: begin
                    pio.out_stb  = 1'b1;
                    pio.out_high = 1'b1;
                end
                op_inp: begin
                    pio.in_stb = 1'b1;
                    dau.dau_op = dau_ldy_pin;
                end
                op_goto: pc_next = instr.field[7:0];
                default: ;
            endcase
        end
    end

endmodule

/* design/dsp_prog_rom.sv */
// Program writes are meant to happen while the core is idle; contents survive reset
`include "dsp_settings.svh"

module dsp_prog_rom import dsp_pkg::*; (
    input  logic                   clk,
    input  logic [`DSP_ROM_AW-1:0] prog_addr,
    input  word_t                  prog_data,
    input  logic                   prog_we,
    input  logic [`DSP_ROM_AW-1:0] fetch_addr,
    output instr_t                 instr
);

    word_t mem [2**`DSP_ROM_AW];

    // One word per programming write
    always_ff @(posedge clk) begin
        if (prog_we) begin
            mem[prog_addr] <= prog_data;
        end
    end

    // Read every cycle; pc is stable through fetch and exec
    always_ff @(posedge clk) begin
        instr <= mem[fetch_addr];
    end

endmodule

/* design/dsp_ram_aau.sv */
// Pointers wrap modulo the RAM size; read data appears the cycle after ram_rd
`include "dsp_settings.svh"

module dsp_ram_aau import dsp_pkg::*; (
    input  logic clk,
    input  logic rst_n,
    aau_if.aau   aau,
    input  word_t a0_word
);

    logic [`DSP_RAM_AW-1:0] ptr [`DSP_NPTR];
    logic [`DSP_RAM_AW-1:0] addr;
    word_t                  mem [2**`DSP_RAM_AW];

    assign addr = ptr[aau.ptr_sel];

    // Pointer registers
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            for (int i = 0; i < `DSP_NPTR; i++) begin
                ptr[i] <= '0;
            end
        end else if (aau.ptr_load) begin
            ptr[aau.ptr_sel] <= aau.ptr_imm;
        end else if ((aau.ram_rd || aau.ram_wr) && aau.post_inc) begin
            // Post-increment uses the address of this access
            ptr[aau.ptr_sel] <= addr + 1'b1;
        end
    end

    // Data RAM
    always_ff @(posedge clk) begin
        if (aau.ram_wr) begin
            mem[addr] <= a0_word;
        end
        if (aau.ram_rd) begin
            aau.ram_dout <= mem[addr];
        end
    end

endmodule

/* design/dsp_dau.sv */
// Product is signed 16x16; accumulator wraps at 36 bits with no saturation
`include "dsp_settings.svh"

module dsp_dau import dsp_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    dau_if.dau    dau,
    input  word_t ram_word,
    input  word_t pin_word
);

    word_t                          x;
    word_t                          y;
    logic signed [2*`DSP_WORD_W-1:0] product;
    acc_t                           product_ext;
    logic                           ldy_ram_pend;

    assign product     = $signed(x) * $signed(y);
    assign product_ext = {{(`DSP_ACC_W-2*`DSP_WORD_W){product[2*`DSP_WORD_W-1]}}, product};

    always_ff @(posedge clk) begin
        if (!rst_n) begin
            x            <= '0;
            y            <= '0;
            dau.a0       <= '0;
            ldy_ram_pend <= 1'b0;
        end else begin
            // RAM data arrives one cycle late, during the next fetch
            ldy_ram_pend <= (dau.dau_op == dau_ldy_ram);
            if (ldy_ram_pend) begin
                y <= ram_word;
            end
            case (dau.dau_op)
                dau_ldx:     x      <= dau.imm;
                dau_ldy_imm: y      <= dau.imm;
                dau_ldy_pin: y      <= pin_word;
                dau_mac:     dau.a0 <= dau.a0 + product_ext;
                dau_clr:     dau.a0 <= '0;
                default: ;
            endcase
        end
    end

endmodule

/* design/dsp_pio.sv */
// Only a0 bits 31..0 reach the port; pids_n follows the decode without a register
`include "dsp_settings.svh"

module dsp_pio import dsp_pkg::*; (
    input  logic  clk,
    input  logic  rst_n,
    pio_if.pio    pio,
    input  acc_t  a0,
    input  word_t pbus_in,
    output word_t pbus_out,
    output logic  pods_n,
    output logic  pids_n
);

    // Output word and one-cycle strobe
    always_ff @(posedge clk) begin
        if (!rst_n) begin
            pbus_out <= '0;
            pods_n   <= 1'b1;
        end else begin
            pods_n <= !pio.out_stb;
            if (pio.out_stb) begin
                pbus_out <= pio.out_high ? a0[2*`DSP_WORD_W-1:`DSP_WORD_W]
                                         : a0[`DSP_WORD_W-1:0];
            end
        end
    end

    // Input strobe low for the exec cycle, DAU samples at its end
    assign pids_n       = !pio.in_stb;
    assign pio.pin_word = pbus_in;

endmodule

/* design/dsp_top.sv */
// Core never stalls; load the program with run low before starting
`include "dsp_settings.svh"

module dsp_top import dsp_pkg::*; (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic                   run,
    input  logic [`DSP_ROM_AW-1:0] prog_addr,
    input  word_t                  prog_data,
    input  logic                   prog_we,
    input  word_t                  pbus_in,
    output word_t                  pbus_out,
    output logic                   pods_n,
    output logic                   pids_n,
    output logic                   halted
);

    logic [`DSP_ROM_AW-1:0] fetch_addr;
    instr_t                 instr;

    aau_if aau_bus ();
    dau_if dau_bus ();
    pio_if pio_bus ();

    dsp_ctrl u_ctrl (
        .clk        ( clk        ),
        .rst_n      ( rst_n      ),
        .run        ( run        ),
        .fetch_addr ( fetch_addr ),
        .instr      ( instr      ),
        .halted     ( halted     ),
        .aau        ( aau_bus    ),
        .dau        ( dau_bus    ),
        .pio        ( pio_bus    )
    );

    dsp_prog_rom u_rom (
        .clk        ( clk        ),
        .prog_addr  ( prog_addr  ),
        .prog_data  ( prog_data  ),
        .prog_we    ( prog_we    ),
        .fetch_addr ( fetch_addr ),
        .instr      ( instr      )
    );

    // RAM stores the low word of a0
    dsp_ram_aau u_ram_aau (
        .clk     ( clk                           ),
        .rst_n   ( rst_n                         ),
        .aau     ( aau_bus                       ),
        .a0_word ( dau_bus.a0[`DSP_WORD_W-1:0]   )
    );

    dsp_dau u_dau (
        .clk      ( clk              ),
        .rst_n    ( rst_n            ),
        .dau      ( dau_bus          ),
        .ram_word ( aau_bus.ram_dout ),
        .pin_word ( pio_bus.pin_word )
    );

    dsp_pio u_pio (
        .clk      ( clk        ),
        .rst_n    ( rst_n      ),
        .pio      ( pio_bus    ),
        .a0       ( dau_bus.a0 ),
        .pbus_in  ( pbus_in    ),
        .pbus_out ( pbus_out   ),
        .pods_n   ( pods_n     ),
        .pids_n   ( pids_n     )
    );

endmodule

/* verif/dsp_clkgen.sv */
// Free-running 4 ns clock from time 0; rst_n stays low for the first 5 rising edges
module dsp_clkgen (
    output logic clk,
    output logic rst_n
);
    timeunit 1ns;
    timeprecision 100ps;

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Synchronous reset, released on a rising edge
    initial begin
        rst_n = 1'b0;
        repeat (5) @(posedge clk);
        rst_n <= 1'b1;
    end

endmodule

/* verif/dsp_tb.sv */
// Programs must reach op_halt within 64 steps and read back only RAM words they wrote first
`include "dsp_settings.svh"

module dsp_tb import dsp_pkg::*; ();
    timeunit 1ns;
    timeprecision 100ps;

    localparam int CYCLE_LIMIT = 3000;
    localparam int HALT_LIMIT  = 200;

    logic                   clk;
    logic                   rst_n;
    logic                   run;
    logic [`DSP_ROM_AW-1:0] prog_addr;
    word_t                  prog_data;
    logic                   prog_we;
    word_t                  pbus_in;
    word_t                  pbus_out;
    logic                   pods_n;
    logic                   pids_n;
    logic                   halted;

    // Program image and expected port activity
    word_t prog [256];
    int    plen;
    word_t exp_out [256];
    int    exp_n = 0;
    int    exp_pins = 0;
    word_t pin_value;

    // Reference model registers start at the core's reset values
    logic signed [`DSP_WORD_W-1:0] m_x = '0;
    logic signed [`DSP_WORD_W-1:0] m_y = '0;
    logic signed [`DSP_ACC_W-1:0]  m_a0 = '0;
    logic [`DSP_RAM_AW-1:0]        m_r [`DSP_NPTR] = '{default: '0};
    word_t                         m_ram [256];

    int   seed = 4;
    int   errors = 0;
    int   ntests = 0;
    int   nfail = 0;
    int   out_idx = 0;
    int   pin_pulses = 0;
    int   cycles = 0;
    logic fresh = 1'b1;
    logic [7:0] base;
    int   target;

    dsp_clkgen clkgen (
        .clk   ( clk   ),
        .rst_n ( rst_n )
    );

    dsp_top dut (
        .clk       ( clk       ),
        .rst_n     ( rst_n     ),
        .run       ( run       ),
        .prog_addr ( prog_addr ),
        .prog_data ( prog_data ),
        .prog_we   ( prog_we   ),
        .pbus_in   ( pbus_in   ),
        .pbus_out  ( pbus_out  ),
        .pods_n    ( pods_n    ),
        .pids_n    ( pids_n    ),
        .halted    ( halted    )
    );

    // Strobe counters
    // pods_n is registered, so the value before the edge marks the pulse
    always @(posedge clk) begin
        if (rst_n && !pods_n) begin
            out_idx <= out_idx + 1;
        end
    end

    always @(negedge clk) begin
        if (!pids_n) begin
            pin_pulses <= pin_pulses + 1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycles >= CYCLE_LIMIT) begin
            $display("Timeout: run stopped after %0d cycles without finishing", cycles);
            $display("Regression failed");
            $finish;
        end
    end

    // Port checks sampled mid-cycle
    // Outputs are unknown until the first reset edge
    a_quiet: assert property (@(negedge clk)
        (fresh && cycles > 0) |-> (pods_n && pids_n && pbus_out == '0 && !halted))
        else begin
            errors++;
            $display("[ERROR] %0t: port or halted not idle after reset", $time);
        end

    a_out_word: assert property (@(negedge clk)
        !pods_n |-> (pbus_out == exp_out[out_idx[7:0]]))
        else begin
            errors++;
            $display("[ERROR] %0t: pbus_out %h, expected %h", $time, pbus_out,
                     exp_out[out_idx[7:0]]);
        end

    a_pods_width: assert property (@(negedge clk) !pods_n |=> pods_n)
        else begin
            errors++;
            $display("[ERROR] %0t: pods_n low for more than one cycle", $time);
        end

    a_pids_width: assert property (@(negedge clk) !pids_n |=> pids_n)
        else begin
            errors++;
            $display("[ERROR] %0t: pids_n low for more than one cycle", $time);
        end

    function automatic logic [11:0] rand12();
        return 12'($random(seed));
    endfunction

    // Field for op_rdy and op_wra
    function automatic logic [11:0] ptr_access(input logic [1:0] n, input logic inc);
        return {n, inc, 9'd0};
    endfunction

    function automatic logic [11:0] ptr_value(input logic [1:0] n, input logic [7:0] v);
        return {n, 2'b00, v};
    endfunction

    task automatic emit(input opcode_e op, input logic [11:0] field);
        prog[plen[7:0]] = {op, field};
        plen++;
    endtask

    task automatic expect_word(input word_t w);
        exp_out[exp_n[7:0]] = w;
        exp_n++;
    endtask

    // Applies the instruction rules from pc 0 until op_halt
    task automatic model_run();
        logic [7:0]         pc;
        opcode_e            op;
        logic [11:0]        f;
        logic [1:0]         n;
        logic signed [31:0] p;
        bit                 done;
        pc   = '0;
        done = 1'b0;
        for (int s = 0; s < 64 && !done; s++) begin
            op = opcode_e'(prog[pc][15:12]);
            f  = prog[pc][11:0];
            n  = f[11:10];
            pc = pc + 8'd1;
            case (op)
                op_halt: done = 1'b1;
                op_ldr:  m_r[n] = f[7:0];
                op_ldx:  m_x = {{4{f[11]}}, f};
                op_ldy:  m_y = {{4{f[11]}}, f};
                op_rdy, op_wra: begin
                    if (op == op_rdy) begin
                        m_y = m_ram[m_r[n]];
                    end else begin
                        m_ram[m_r[n]] = m_a0[15:0];
                    end
                    if (f[9]) begin
                        m_r[n] = m_r[n] + 8'd1;
                    end
                end
                op_mac: begin
                    p    = 32'(m_x) * 32'(m_y);
                    m_a0 = m_a0 + {{4{p[31]}}, p};
                end
                op_clr:  m_a0 = '0;
                op_outl: expect_word(m_a0[15:0]);
                op_outh: expect_word(m_a0[31:16]);
                op_inp: begin
                    m_y = pin_value;
                    exp_pins++;
                end
                op_goto: pc = f[7:0];
                default: ;
            endcase
        end
    endtask

    task automatic load_program();
        for (int i = 0; i < plen; i++) begin
            @(posedge clk);
            prog_we   <= 1'b1;
            prog_addr <= 8'(i);
            prog_data <= prog[i[7:0]];
        end
        @(posedge clk);
        prog_we <= 1'b0;
    endtask

    task automatic start_and_wait(output bit ok);
        int n;
        @(posedge clk);
        run <= 1'b1;
        n = 0;
        @(negedge clk);
        while (!halted && n < HALT_LIMIT) begin
            @(negedge clk);
            n++;
        end
        ok = halted;
        @(posedge clk);
        run <= 1'b0;
        repeat (2) @(posedge clk);
    endtask

    task automatic report_test(input string name, input int err0);
        ntests++;
        if (errors == err0) begin
            $display("test %s: PASS", name);
        end else begin
            nfail++;
            $display("test %s: FAIL with %0d errors", name, errors - err0);
        end
    endtask

    // Runs the program in prog the given number of times, restarting from address 0
    task automatic run_test(input string name, input int runs);
        int err0;
        bit ok;
        err0 = errors;
        for (int k = 0; k < runs; k++) begin
            model_run();
        end
        load_program();
        for (int k = 0; k < runs; k++) begin
            start_and_wait(ok);
            if (!ok) begin
                errors++;
                $display("Program %s did not halt within %0d cycles", name, HALT_LIMIT);
            end
        end
        assert (out_idx == exp_n) else begin
            errors++;
            $display("[ERROR] %0t: %s gave %0d output strobes, expected %0d",
                     $time, name, out_idx, exp_n);
        end
        assert (pin_pulses == exp_pins) else begin
            errors++;
            $display("[ERROR] %0t: %s gave %0d input strobes, expected %0d",
                     $time, name, pin_pulses, exp_pins);
        end
        report_test(name, err0);
    endtask

    initial begin
        run       = 1'b0;
        prog_addr = '0;
        prog_data = '0;
        prog_we   = 1'b0;
        pbus_in   = '0;
        pin_value = '0;
        while (rst_n !== 1'b1) begin
            @(posedge clk);
        end
        repeat (3) @(posedge clk);
        report_test("reset", 0);
        fresh <= 1'b0;

        plen = 0;
        emit(op_nop, 12'd0);
        emit(op_clr, 12'd0);
        repeat (4) begin
            emit(op_ldx, rand12());
            emit(op_ldy, rand12());
            emit(op_mac, 12'd0);
        end
        emit(op_outl, 12'd0);
        emit(op_outh, 12'd0);
        emit(op_halt, 12'd0);
        run_test("mac", 1);

        // Three words stored through r2 and read back after reloading it
        base = 8'($random(seed));
        plen = 0;
        emit(op_clr, 12'd0);
        emit(op_ldx, rand12());
        emit(op_ldy, rand12());
        emit(op_ldr, ptr_value(2'd2, base));
        repeat (3) begin
            emit(op_mac, 12'd0);
            emit(op_wra, ptr_access(2'd2, 1'b1));
        end
        emit(op_ldr, ptr_value(2'd2, base));
        emit(op_clr, 12'd0);
        emit(op_ldx, rand12());
        repeat (3) begin
            emit(op_rdy, ptr_access(2'd2, 1'b1));
            emit(op_mac, 12'd0);
        end
        emit(op_outl, 12'd0);
        emit(op_outh, 12'd0);
        emit(op_halt, 12'd0);
        run_test("ram", 1);

        pin_value = 16'($random(seed));
        @(posedge clk);
        pbus_in <= pin_value;
        plen = 0;
        emit(op_clr, 12'd0);
        emit(op_ldx, rand12());
        emit(op_inp, 12'd0);
        emit(op_mac, 12'd0);
        emit(op_outl, 12'd0);
        emit(op_outh, 12'd0);
        emit(op_halt, 12'd0);
        run_test("input", 1);

        // The op_goto jumps over one op_outl
        plen = 0;
        emit(op_clr, 12'd0);
        emit(op_ldx, rand12());
        emit(op_ldy, rand12());
        emit(op_mac, 12'd0);
        target = plen + 2;
        emit(op_goto, {4'd0, 8'(target)});
        emit(op_outl, 12'd0);
        emit(op_outl, 12'd0);
        emit(op_outh, 12'd0);
        emit(op_halt, 12'd0);
        run_test("goto", 2);

        $display("tests %0d, failed %0d, errors %0d", ntests, nfail, errors);
        if (errors == 0) begin
            $display("Regression passed");
        end else begin
            $display("Regression failed");
        end
        $finish;
    end

endmodule

/* list.f */
+incdir+design
design/dsp_pkg.sv
design/dsp_if.sv
design/dsp_ctrl.sv
design/dsp_prog_rom.sv
design/dsp_ram_aau.sv
design/dsp_dau.sv
design/dsp_pio.sv
design/dsp_top.sv
verif/dsp_clkgen.sv
verif/dsp_tb.sv

/* run.sh */
#!/bin/sh
# Compile with Verilator, run, and decide pass or fail from the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir sim.log

verilator --binary --timing --assert -Wno-fatal --top-module dsp_tb -f list.f -o dsp_sim
if [ $? -ne 0 ]; then
    echo "Verilator compile failed"
    exit 1
fi

./obj_dir/dsp_sim > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "Simulation exited with status $status"
    exit 1
fi

if grep -q "Regression failed" sim.log; then
    exit 1
fi
exit 0
